// File: verilog/coherence_ctrl_config.svh
////////////////////
// Coherence controller back end configuration
// Widths, port count, capacities and credits
////////////////////

`ifndef COHERENCE_CTRL_CONFIG_SVH
`define COHERENCE_CTRL_CONFIG_SVH

// Address and line geometry
`define CC_ADDR_WIDTH      32
`define CC_LINE_BYTES_LOG2 6
`define CC_ID_WIDTH        4

// Snooped masters and CD beat width
`define CC_NUM_PORTS       4
`define CC_CD_WIDTH        64

// Capacities
`define CC_TRACKER_DEPTH   4
`define CC_ORDER_DEPTH     4
`define CC_CD_CREDITS      2

`endif

// File: verilog/coherence_ctrl_pkg.sv
////////////////////
// Coherence controller shared types
////////////////////

`include "coherence_ctrl_config.svh"

package coherence_ctrl_pkg;

    typedef logic [`CC_ADDR_WIDTH-1:0] addr_t;

    // Address without the byte offset inside a line
    typedef logic [`CC_ADDR_WIDTH-`CC_LINE_BYTES_LOG2-1:0] line_t;

    typedef logic [`CC_ID_WIDTH-1:0] txn_id_t;

    // Snoop port selection
    typedef logic [$clog2(`CC_NUM_PORTS)-1:0] port_idx_t;
    typedef logic [`CC_NUM_PORTS-1:0]         port_mask_t;

    typedef logic [`CC_CD_WIDTH-1:0] cd_data_t;

    // Holds 0 up to the full credit count
    typedef logic [$clog2(`CC_CD_CREDITS+1)-1:0] credit_t;

    // Unit that receives the forwarded snoop data
    typedef enum logic {
        MEMORY_UNIT,
        SNOOP_UNIT
    } cd_owner_e;

endpackage

// File: verilog/line_tracker.sv
////////////////////
// Line tracker
// Outstanding transactions by ID with line collision lookup
////////////////////

`timescale 1ns/10ps

`include "coherence_ctrl_config.svh"

module line_tracker (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        lookup_req_i,
    input  coherence_ctrl_pkg::addr_t   lookup_addr_i,
    input  logic                        push_i,
    input  coherence_ctrl_pkg::txn_id_t push_id_i,
    input  coherence_ctrl_pkg::addr_t   push_addr_i,
    input  logic                        done_i,
    input  coherence_ctrl_pkg::txn_id_t done_id_i,
    output logic                        collision_o,
    output logic                        full_o
);

    localparam int Depth = `CC_TRACKER_DEPTH;
    localparam int AgeW  = $clog2(Depth);

    logic                        valid_q [Depth];
    coherence_ctrl_pkg::txn_id_t id_q    [Depth];
    coherence_ctrl_pkg::line_t   line_q  [Depth];
    // Rank among valid entries, 0 is the oldest
    logic [AgeW-1:0]             age_q   [Depth];

    coherence_ctrl_pkg::line_t lookup_line;
    coherence_ctrl_pkg::line_t push_line;
    logic                      push_acc;
    logic                      hit;
    logic                      rel_found;
    logic [AgeW-1:0]           rel_idx;
    logic [AgeW-1:0]           free_idx;
    logic [AgeW:0]             valid_cnt;
    logic [AgeW-1:0]           new_age;

    assign lookup_line = lookup_addr_i[`CC_ADDR_WIDTH-1:`CC_LINE_BYTES_LOG2];
    assign push_line   = push_addr_i[`CC_ADDR_WIDTH-1:`CC_LINE_BYTES_LOG2];

    always_comb begin
        hit       = 1'b0;
        rel_found = 1'b0;
        rel_idx   = '0;
        free_idx  = '0;
        valid_cnt = '0;
        full_o    = 1'b1;
        for (int i = Depth - 1; i >= 0; i--) begin
            if (valid_q[i] && line_q[i] == lookup_line) begin
                hit = 1'b1;
            end
            if (!valid_q[i]) begin
                free_idx = AgeW'(i);
                full_o   = 1'b0;
            end
            valid_cnt = valid_cnt + (AgeW+1)'(valid_q[i]);
        end
        // Oldest entry with the released ID
        for (int i = 0; i < Depth; i++) begin
            if (done_i && valid_q[i] && id_q[i] == done_id_i &&
                (!rel_found || age_q[i] < age_q[rel_idx])) begin
                rel_found = 1'b1;
                rel_idx   = AgeW'(i);
            end
        end
    end

    assign collision_o = lookup_req_i && hit;
    assign push_acc    = push_i && !full_o;
    assign new_age     = AgeW'(valid_cnt - (AgeW+1)'(rel_found));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < Depth; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            if (rel_found) begin
                valid_q[rel_idx] <= 1'b0;
            end
            if (push_acc) begin
                valid_q[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < Depth; i++) begin
            if (rel_found && valid_q[i] && age_q[i] > age_q[rel_idx]) begin
                age_q[i] <= age_q[i] - 1'b1;
            end
        end
        if (push_acc) begin
            id_q[free_idx]   <= push_id_i;
            line_q[free_idx] <= push_line;
            age_q[free_idx]  <= new_age;
        end
    end

    // A push against a full table adds no entry
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (push_i && full_o) |=>
        (valid_cnt == $past(valid_cnt) - (AgeW+1)'($past(rel_found))));

endmodule

// File: verilog/cd_order_queue.sv
////////////////////
// CD order queue
// Arbitrates unit requests into a fall-through order FIFO
////////////////////

`timescale 1ns/10ps

`include "coherence_ctrl_config.svh"

module cd_order_queue (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           mu_wb_valid_i,
    input  logic                           su_snp_valid_i,
    input  coherence_ctrl_pkg::port_idx_t  responder_i,
    input  coherence_ctrl_pkg::port_mask_t avail_i,
    output logic                           mu_wb_ack_o,
    output logic                           su_snp_ack_o,
    output logic                           head_valid_o,
    output coherence_ctrl_pkg::cd_owner_e  head_owner_o,
    output coherence_ctrl_pkg::port_idx_t  head_responder_o,
    output coherence_ctrl_pkg::port_mask_t head_avail_o,
    input  logic                           head_pop_i
);

    localparam int Depth = `CC_ORDER_DEPTH;
    localparam int PtrW  = $clog2(Depth);

    coherence_ctrl_pkg::cd_owner_e  owner_mem [Depth];
    coherence_ctrl_pkg::port_idx_t  resp_mem  [Depth];
    coherence_ctrl_pkg::port_mask_t avail_mem [Depth];

    logic [PtrW-1:0]               wr_ptr_q;
    logic [PtrW-1:0]               rd_ptr_q;
    logic [PtrW:0]                 count_q;
    logic                          full;
    logic                          empty;
    logic                          push;
    logic                          store;
    logic                          pop_mem;
    coherence_ctrl_pkg::cd_owner_e push_owner;

    assign full  = count_q == (PtrW+1)'(Depth);
    assign empty = count_q == '0;

    // Memory unit has priority
    assign mu_wb_ack_o  = mu_wb_valid_i && !full;
    assign su_snp_ack_o = su_snp_valid_i && !mu_wb_valid_i && !full;
    assign push         = mu_wb_ack_o || su_snp_ack_o;
    assign push_owner   = mu_wb_valid_i ? coherence_ctrl_pkg::MEMORY_UNIT
                                        : coherence_ctrl_pkg::SNOOP_UNIT;

    // Empty FIFO passes the new order straight to the head
    assign head_valid_o     = !empty || push;
    assign head_owner_o     = empty ? push_owner  : owner_mem[rd_ptr_q];
    assign head_responder_o = empty ? responder_i : resp_mem[rd_ptr_q];
    assign head_avail_o     = empty ? avail_i     : avail_mem[rd_ptr_q];

    assign store   = push && !(empty && head_pop_i);
    assign pop_mem = head_pop_i && !empty;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (store) begin
                wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_mem) begin
                rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (PtrW+1)'(store) - (PtrW+1)'(pop_mem);
        end
    end

    always_ff @(posedge clk_i) begin
        if (store) begin
            owner_mem[wr_ptr_q] <= push_owner;
            resp_mem[wr_ptr_q]  <= responder_i;
            avail_mem[wr_ptr_q] <= avail_i;
        end
    end

    // Router only retires an order that is present
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        head_pop_i |-> head_valid_o);

endmodule

// File: verilog/cd_router.sv
////////////////////
// CD router
// Collects snoop data and forwards the responder to its unit
////////////////////

`timescale 1ns/10ps

`include "coherence_ctrl_config.svh"

module cd_router (
    input  logic                                               clk_i,
    input  logic                                               rst_ni,
    input  logic                                               head_valid_i,
    input  coherence_ctrl_pkg::cd_owner_e                      head_owner_i,
    input  coherence_ctrl_pkg::port_idx_t                      head_responder_i,
    input  coherence_ctrl_pkg::port_mask_t                     head_avail_i,
    output logic                                               head_pop_o,
    input  coherence_ctrl_pkg::port_mask_t                     cd_valid_i,
    input  coherence_ctrl_pkg::cd_data_t [`CC_NUM_PORTS-1:0]   cd_data_i,
    input  coherence_ctrl_pkg::port_mask_t                     cd_last_i,
    output coherence_ctrl_pkg::port_mask_t                     cd_ready_o,
    output logic                                               mu_cd_valid_o,
    output logic                                               su_cd_valid_o,
    output coherence_ctrl_pkg::cd_data_t                       cd_data_o,
    output logic                                               cd_last_o,
    input  logic                                               mu_cd_credit_i,
    input  logic                                               su_cd_credit_i
);

    localparam coherence_ctrl_pkg::credit_t MaxCredits =
        coherence_ctrl_pkg::credit_t'(`CC_CD_CREDITS);

    coherence_ctrl_pkg::port_mask_t last_q;
    coherence_ctrl_pkg::port_mask_t last_set;
    coherence_ctrl_pkg::credit_t    credit_q [2];

    logic       owner_sel;
    logic       owner_has_credit;
    logic       fwd;
    logic [1:0] unit_spend;
    logic [1:0] unit_ret;

    ////////////////////
    // Ready and forwarding
    ////////////////////

    // Index 0 is the memory unit, 1 the snoop unit
    assign owner_sel        = head_owner_i == coherence_ctrl_pkg::SNOOP_UNIT;
    assign owner_has_credit = credit_q[owner_sel] != '0;

    for (genvar i = 0; i < `CC_NUM_PORTS; i++) begin : g_ready
        assign cd_ready_o[i] = head_valid_i && head_avail_i[i] && !last_q[i] &&
            (head_responder_i != coherence_ctrl_pkg::port_idx_t'(i) || owner_has_credit);
    end

    // Beats of other ports are taken and dropped
    assign fwd           = cd_valid_i[head_responder_i] && cd_ready_o[head_responder_i];
    assign mu_cd_valid_o = fwd && !owner_sel;
    assign su_cd_valid_o = fwd && owner_sel;
    assign cd_data_o     = cd_data_i[head_responder_i];
    assign cd_last_o     = cd_last_i[head_responder_i];

    ////////////////////
    // Order retirement
    ////////////////////

    assign last_set   = cd_valid_i & cd_ready_o & cd_last_i;
    assign head_pop_o = head_valid_i && (last_q == head_avail_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_q <= '0;
        end else if (head_pop_o) begin
            last_q <= '0;
        end else begin
            last_q <= last_q | last_set;
        end
    end

    ////////////////////
    // Credits
    ////////////////////

    assign unit_spend = {su_cd_valid_o, mu_cd_valid_o};
    assign unit_ret   = {su_cd_credit_i, mu_cd_credit_i};

    for (genvar u = 0; u < 2; u++) begin : g_credit
        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                credit_q[u] <= MaxCredits;
            end else if (unit_spend[u] && !unit_ret[u]) begin
                credit_q[u] <= credit_q[u] - 1'b1;
            end else if (!unit_spend[u] && unit_ret[u] && credit_q[u] != MaxCredits) begin
                // Surplus returns are dropped
                credit_q[u] <= credit_q[u] + 1'b1;
            end
        end

        assert property (@(posedge clk_i) disable iff (!rst_ni)
            credit_q[u] <= MaxCredits);

        // Forwarded beat needs a credit of its unit
        assert property (@(posedge clk_i) disable iff (!rst_ni)
            unit_spend[u] |-> credit_q[u] != '0);
    end

endmodule

// File: verilog/coherence_ctrl.sv
////////////////////
// Coherence controller back end
// Line collision trackers and snoop data ordering
////////////////////

`timescale 1ns/10ps

`include "coherence_ctrl_config.svh"

module coherence_ctrl (
    input  logic                                             clk_i,
    input  logic                                             rst_ni,
    // Collision lookup
    input  logic                                             lookup_req_i,
    input  coherence_ctrl_pkg::addr_t                        lookup_addr_i,
    output logic                                             wr_collision_o,
    output logic                                             rd_collision_o,
    // Tracker insert and release
    input  logic                                             wr_push_i,
    input  coherence_ctrl_pkg::txn_id_t                      wr_push_id_i,
    input  coherence_ctrl_pkg::addr_t                        wr_push_addr_i,
    input  logic                                             rd_push_i,
    input  coherence_ctrl_pkg::txn_id_t                      rd_push_id_i,
    input  coherence_ctrl_pkg::addr_t                        rd_push_addr_i,
    input  logic                                             wr_done_i,
    input  coherence_ctrl_pkg::txn_id_t                      wr_done_id_i,
    input  logic                                             rd_done_i,
    input  coherence_ctrl_pkg::txn_id_t                      rd_done_id_i,
    output logic                                             wr_full_o,
    output logic                                             rd_full_o,
    // Order requests
    input  logic                                             mu_wb_valid_i,
    input  logic                                             su_snp_valid_i,
    input  coherence_ctrl_pkg::port_idx_t                    order_responder_i,
    input  coherence_ctrl_pkg::port_mask_t                   order_avail_i,
    output logic                                             mu_wb_ack_o,
    output logic                                             su_snp_ack_o,
    // Snoop CD ports
    input  coherence_ctrl_pkg::port_mask_t                   cd_valid_i,
    input  coherence_ctrl_pkg::cd_data_t [`CC_NUM_PORTS-1:0] cd_data_i,
    input  coherence_ctrl_pkg::port_mask_t                   cd_last_i,
    output coherence_ctrl_pkg::port_mask_t                   cd_ready_o,
    // Forwarded CD with credits
    output logic                                             mu_cd_valid_o,
    output logic                                             su_cd_valid_o,
    output coherence_ctrl_pkg::cd_data_t                     cd_data_o,
    output logic                                             cd_last_o,
    input  logic                                             mu_cd_credit_i,
    input  logic                                             su_cd_credit_i
);

    logic                           head_valid;
    coherence_ctrl_pkg::cd_owner_e  head_owner;
    coherence_ctrl_pkg::port_idx_t  head_responder;
    coherence_ctrl_pkg::port_mask_t head_avail;
    logic                           head_pop;

    line_tracker wr_tracker_i (
        .clk_i, .rst_ni, .lookup_req_i, .lookup_addr_i,
        .push_i (wr_push_i), .push_id_i (wr_push_id_i), .push_addr_i (wr_push_addr_i),
        .done_i (wr_done_i), .done_id_i (wr_done_id_i),
        .collision_o (wr_collision_o), .full_o (wr_full_o)
    );

    line_tracker rd_tracker_i (
        .clk_i, .rst_ni, .lookup_req_i, .lookup_addr_i,
        .push_i (rd_push_i), .push_id_i (rd_push_id_i), .push_addr_i (rd_push_addr_i),
        .done_i (rd_done_i), .done_id_i (rd_done_id_i),
        .collision_o (rd_collision_o), .full_o (rd_full_o)
    );

    cd_order_queue cd_order_queue_i (
        .clk_i, .rst_ni, .mu_wb_valid_i, .su_snp_valid_i,
        .responder_i (order_responder_i), .avail_i (order_avail_i),
        .mu_wb_ack_o, .su_snp_ack_o,
        .head_valid_o (head_valid), .head_owner_o (head_owner),
        .head_responder_o (head_responder), .head_avail_o (head_avail),
        .head_pop_i (head_pop)
    );

    cd_router cd_router_i (
        .clk_i, .rst_ni,
        .head_valid_i (head_valid), .head_owner_i (head_owner),
        .head_responder_i (head_responder), .head_avail_i (head_avail),
        .head_pop_o (head_pop),
        .cd_valid_i, .cd_data_i, .cd_last_i, .cd_ready_o,
        .mu_cd_valid_o, .su_cd_valid_o, .cd_data_o, .cd_last_o,
        .mu_cd_credit_i, .su_cd_credit_i
    );

endmodule

// File: test/tb_coherence_ctrl.sv
////////////////////
// Coherence controller testbench
// Random stimulus checked against tracker, order and credit models
////////////////////

`timescale 1ns/10ps

`include "coherence_ctrl_config.svh"

module tb_coherence_ctrl;

    localparam int MaxCycles = 4000;
    localparam int MaxOrders = 1024;

    logic clk_i;
    logic rst_ni;

    logic                                             lookup_req;
    coherence_ctrl_pkg::addr_t                        lookup_addr;
    logic                                             t_push    [2];
    coherence_ctrl_pkg::txn_id_t                      t_push_id [2];
    coherence_ctrl_pkg::addr_t                        t_push_addr [2];
    logic                                             t_done    [2];
    coherence_ctrl_pkg::txn_id_t                      t_done_id [2];
    logic                                             wr_collision, rd_collision;
    logic                                             wr_full, rd_full;
    logic                                             mu_v, su_v;
    coherence_ctrl_pkg::port_idx_t                    req_resp;
    coherence_ctrl_pkg::port_mask_t                   req_avail;
    int                                               req_len;
    logic                                             mu_wb_ack, su_snp_ack;
    coherence_ctrl_pkg::port_mask_t                   cd_valid, cd_last, cd_ready;
    coherence_ctrl_pkg::cd_data_t [`CC_NUM_PORTS-1:0] cd_data;
    logic                                             mu_cd_valid, su_cd_valid;
    coherence_ctrl_pkg::cd_data_t                     cd_data_out;
    logic                                             cd_last_out;
    logic                                             mu_cr, su_cr;

    // Phase control
    logic trk_en, ord_en, credit_en, both_req, hold;

    logic [31:0] seed;
    int          errors;
    int          cycles;
    int          p_ptr  [`CC_NUM_PORTS];
    int          p_beat [`CC_NUM_PORTS];

    coherence_ctrl coherence_ctrl_i (
        .clk_i, .rst_ni,
        .lookup_req_i (lookup_req), .lookup_addr_i (lookup_addr),
        .wr_collision_o (wr_collision), .rd_collision_o (rd_collision),
        .wr_push_i (t_push[0]), .wr_push_id_i (t_push_id[0]), .wr_push_addr_i (t_push_addr[0]),
        .rd_push_i (t_push[1]), .rd_push_id_i (t_push_id[1]), .rd_push_addr_i (t_push_addr[1]),
        .wr_done_i (t_done[0]), .wr_done_id_i (t_done_id[0]),
        .rd_done_i (t_done[1]), .rd_done_id_i (t_done_id[1]),
        .wr_full_o (wr_full), .rd_full_o (rd_full),
        .mu_wb_valid_i (mu_v), .su_snp_valid_i (su_v),
        .order_responder_i (req_resp), .order_avail_i (req_avail),
        .mu_wb_ack_o (mu_wb_ack), .su_snp_ack_o (su_snp_ack),
        .cd_valid_i (cd_valid), .cd_data_i (cd_data), .cd_last_i (cd_last),
        .cd_ready_o (cd_ready),
        .mu_cd_valid_o (mu_cd_valid), .su_cd_valid_o (su_cd_valid),
        .cd_data_o (cd_data_out), .cd_last_o (cd_last_out),
        .mu_cd_credit_i (mu_cr), .su_cd_credit_i (su_cr)
    );

    always #20 clk_i = ~clk_i;

    function logic [31:0] next_rand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    // Eight lines in the pool so that collisions are frequent
    function coherence_ctrl_pkg::addr_t make_addr(input logic [31:0] r);
        coherence_ctrl_pkg::line_t line;
        line = coherence_ctrl_pkg::line_t'(26'h100 + {23'd0, r[2:0]});
        return {line, r[13:8]};
    endfunction

    function coherence_ctrl_pkg::cd_data_t beat_data(input int seq, input int port,
                                                    input int idx);
        return {32'(seq), 16'(port), 16'(idx)};
    endfunction

    function coherence_ctrl_pkg::line_t line_of(input coherence_ctrl_pkg::addr_t a);
        return a[`CC_ADDR_WIDTH-1:`CC_LINE_BYTES_LOG2];
    endfunction

    task report_error(input string msg);
        errors++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    ////////////////////
    // Reference models
    ////////////////////

    // Tracker entries kept oldest first
    coherence_ctrl_pkg::line_t   m_line [2][`CC_TRACKER_DEPTH];
    coherence_ctrl_pkg::txn_id_t m_id   [2][`CC_TRACKER_DEPTH];
    int                          m_cnt  [2];
    logic                        exp_coll [2];
    logic                        exp_full [2];

    always_comb begin
        for (int t = 0; t < 2; t++) begin
            exp_full[t] = m_cnt[t] == `CC_TRACKER_DEPTH;
            exp_coll[t] = 1'b0;
            for (int j = 0; j < `CC_TRACKER_DEPTH; j++) begin
                if (j < m_cnt[t] && m_line[t][j] == line_of(lookup_addr) && lookup_req) begin
                    exp_coll[t] = 1'b1;
                end
            end
        end
    end

    always @(posedge clk_i or negedge rst_ni) begin
        int n;
        int k;
        if (!rst_ni) begin
            m_cnt[0] = 0;
            m_cnt[1] = 0;
        end else begin
            for (int t = 0; t < 2; t++) begin
                n = m_cnt[t];
                k = -1;
                for (int j = 0; j < `CC_TRACKER_DEPTH; j++) begin
                    if (t_done[t] && k < 0 && j < n && m_id[t][j] == t_done_id[t]) begin
                        k = j;
                    end
                end
                if (k >= 0) begin
                    for (int j = k; j < `CC_TRACKER_DEPTH - 1; j++) begin
                        m_line[t][j] = m_line[t][j+1];
                        m_id[t][j]   = m_id[t][j+1];
                    end
                    n--;
                end
                if (t_push[t] && m_cnt[t] < `CC_TRACKER_DEPTH) begin
                    m_line[t][n] = line_of(t_push_addr[t]);
                    m_id[t][n]   = t_push_id[t];
                    n++;
                end
                m_cnt[t] = n;
            end
        end
    end

    // Orders by sequence number, head_seq is the oldest pending one
    coherence_ctrl_pkg::cd_owner_e  ord_owner [MaxOrders];
    coherence_ctrl_pkg::port_idx_t  ord_resp  [MaxOrders];
    coherence_ctrl_pkg::port_mask_t ord_avail [MaxOrders];
    int                             ord_len   [MaxOrders];
    int                             n_orders, head_seq, fwd_cnt;
    coherence_ctrl_pkg::port_mask_t m_last;
    int                             m_credit [2];
    int                             held_beats [2];

    int                             occ;
    logic                           e_mu_ack, e_su_ack, hp, e_fwd, e_last;
    coherence_ctrl_pkg::cd_owner_e  new_owner, h_owner;
    coherence_ctrl_pkg::port_idx_t  h_resp;
    coherence_ctrl_pkg::port_mask_t h_avail, e_ready;
    int                             h_len;
    coherence_ctrl_pkg::cd_data_t   e_data;

    always_comb begin
        occ       = n_orders - head_seq;
        e_mu_ack  = mu_v && occ < `CC_ORDER_DEPTH;
        e_su_ack  = su_v && !mu_v && occ < `CC_ORDER_DEPTH;
        hp        = occ > 0 || e_mu_ack || e_su_ack;
        new_owner = mu_v ? coherence_ctrl_pkg::MEMORY_UNIT : coherence_ctrl_pkg::SNOOP_UNIT;
        h_owner   = occ > 0 ? ord_owner[head_seq] : new_owner;
        h_resp    = occ > 0 ? ord_resp[head_seq]  : req_resp;
        h_avail   = occ > 0 ? ord_avail[head_seq] : req_avail;
        h_len     = occ > 0 ? ord_len[head_seq]   : req_len;
        for (int i = 0; i < `CC_NUM_PORTS; i++) begin
            e_ready[i] = hp && h_avail[i] && !m_last[i] &&
                (int'(h_resp) != i || m_credit[int'(h_owner)] > 0);
        end
        e_fwd  = cd_valid[h_resp] && e_ready[h_resp];
        e_data = beat_data(head_seq, int'(h_resp), fwd_cnt);
        e_last = fwd_cnt == h_len - 1;
    end

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            n_orders   <= 0;
            head_seq   <= 0;
            fwd_cnt    <= 0;
            m_last     <= '0;
            m_credit   <= '{`CC_CD_CREDITS, `CC_CD_CREDITS};
            held_beats <= '{0, 0};
        end else begin
            if (e_mu_ack || e_su_ack) begin
                ord_owner[n_orders] <= new_owner;
                ord_resp[n_orders]  <= req_resp;
                ord_avail[n_orders] <= req_avail;
                ord_len[n_orders]   <= req_len;
                n_orders            <= n_orders + 1;
            end
            // Retire one cycle after the final last beat
            if (occ > 0 && m_last == ord_avail[head_seq]) begin
                head_seq <= head_seq + 1;
                m_last   <= '0;
                fwd_cnt  <= 0;
            end else begin
                m_last <= m_last | (cd_valid & e_ready & cd_last);
                if (e_fwd) begin
                    fwd_cnt <= fwd_cnt + 1;
                end
            end
            for (int u = 0; u < 2; u++) begin
                if (e_fwd && int'(h_owner) == u && !(u == 1 ? su_cr : mu_cr)) begin
                    m_credit[u] <= m_credit[u] - 1;
                end else if (!(e_fwd && int'(h_owner) == u) && (u == 1 ? su_cr : mu_cr) &&
                             m_credit[u] < `CC_CD_CREDITS) begin
                    m_credit[u] <= m_credit[u] + 1;
                end
                if (!hold) begin
                    held_beats[u] <= 0;
                end else if (e_fwd && int'(h_owner) == u) begin
                    held_beats[u] <= held_beats[u] + 1;
                end
            end
        end
    end

    ////////////////////
    // Assertions
    ////////////////////

    assert property (@(posedge clk_i) !rst_ni |-> !(wr_collision || rd_collision || wr_full ||
        rd_full || mu_wb_ack || su_snp_ack || mu_cd_valid || su_cd_valid || |cd_ready))
        else report_error("output active during reset");
    assert property (@(posedge clk_i) disable iff (!rst_ni) wr_collision == exp_coll[0])
        else report_error("wr_collision_o mismatch");
    assert property (@(posedge clk_i) disable iff (!rst_ni) rd_collision == exp_coll[1])
        else report_error("rd_collision_o mismatch");
    assert property (@(posedge clk_i) disable iff (!rst_ni) wr_full == exp_full[0])
        else report_error("wr_full_o mismatch");
    assert property (@(posedge clk_i) disable iff (!rst_ni) rd_full == exp_full[1])
        else report_error("rd_full_o mismatch");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mu_wb_ack == e_mu_ack && su_snp_ack == e_su_ack)
        else report_error("order ack mismatch");
    assert property (@(posedge clk_i) disable iff (!rst_ni) cd_ready == e_ready)
        else report_error("cd_ready_o mismatch");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mu_cd_valid == (e_fwd && h_owner == coherence_ctrl_pkg::MEMORY_UNIT) &&
        su_cd_valid == (e_fwd && h_owner == coherence_ctrl_pkg::SNOOP_UNIT))
        else report_error("forwarded valid mismatch");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        e_fwd |-> cd_data_out == e_data && cd_last_out == e_last)
        else report_error("forwarded beat data or last mismatch");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        held_beats[0] <= `CC_CD_CREDITS && held_beats[1] <= `CC_CD_CREDITS)
        else report_error("more beats than credits while returns withheld");

    ////////////////////
    // Stimulus
    ////////////////////

    always @(posedge clk_i) begin
        logic [31:0] r;
        if (rst_ni) begin
            for (int t = 0; t < 2; t++) begin
                r = next_rand();
                t_push[t]      <= trk_en && r[0];
                t_push_id[t]   <= coherence_ctrl_pkg::txn_id_t'(r[5:4]);
                t_push_addr[t] <= make_addr(next_rand());
                t_done[t]      <= trk_en && r[9:8] == 2'd0;
                t_done_id[t]   <= coherence_ctrl_pkg::txn_id_t'(r[13:12]);
            end
            r = next_rand();
            lookup_req  <= r[1:0] != 2'd0;
            lookup_addr <= make_addr(next_rand());
            r = next_rand();
            if (both_req) begin
                mu_v <= 1'b1;
                su_v <= 1'b1;
            end else begin
                if (!mu_v || mu_wb_ack) begin
                    mu_v <= ord_en && r[1:0] == 2'd0;
                end
                if (!su_v || su_snp_ack) begin
                    su_v <= ord_en && r[3:2] == 2'd0;
                end
            end
            if ((!mu_v && !su_v) || mu_wb_ack || su_snp_ack) begin
                req_resp  <= coherence_ctrl_pkg::port_idx_t'(r[9:8]);
                req_avail <= r[15:12] | (4'b0001 << r[9:8]);
                req_len   <= 1 + int'(r[17:16] % 2'd3);
            end
            mu_cr <= credit_en && r[20];
            su_cr <= credit_en && r[21];
            // Snoop ports stream every order that announced them
            for (int i = 0; i < `CC_NUM_PORTS; i++) begin
                if (cd_valid[i] && cd_ready[i]) begin
                    if (cd_last[i]) begin
                        p_ptr[i]++;
                        p_beat[i] = 0;
                    end else begin
                        p_beat[i]++;
                    end
                end
                while (p_ptr[i] < n_orders && !ord_avail[p_ptr[i]][i]) begin
                    p_ptr[i]++;
                end
                r = next_rand();
                if (p_ptr[i] < n_orders && r[1:0] != 2'd0) begin
                    cd_valid[i] <= 1'b1;
                    cd_data[i]  <= beat_data(p_ptr[i], i, p_beat[i]);
                    cd_last[i]  <= p_beat[i] == ord_len[p_ptr[i]] - 1;
                end else begin
                    cd_valid[i] <= 1'b0;
                    cd_last[i]  <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MaxCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        seed = 32'h853a;
        errors = 0;
        cycles = 0;
        clk_i = 1'b0;
        rst_ni = 1'b0;
        lookup_req = 1'b0;
        lookup_addr = '0;
        for (int t = 0; t < 2; t++) begin
            t_push[t] = 1'b0;
            t_push_id[t] = '0;
            t_push_addr[t] = '0;
            t_done[t] = 1'b0;
            t_done_id[t] = '0;
        end
        {mu_v, su_v, mu_cr, su_cr} = 4'b0;
        {trk_en, ord_en, credit_en, both_req, hold} = 5'b0;
        req_resp = '0;
        req_avail = 4'b0001;
        req_len = 1;
        cd_valid = '0;
        cd_last = '0;
        cd_data = '0;
        for (int i = 0; i < `CC_NUM_PORTS; i++) begin
            p_ptr[i] = 0;
            p_beat[i] = 0;
        end
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        trk_en <= 1'b1;
        ord_en <= 1'b1;
        credit_en <= 1'b1;
        repeat (1000) @(posedge clk_i);
        // Withhold credits and fill the order FIFO
        credit_en <= 1'b0;
        both_req <= 1'b1;
        // Last credit return still in flight lands first
        @(posedge clk_i);
        hold <= 1'b1;
        repeat (60) @(posedge clk_i);
        credit_en <= 1'b1;
        both_req <= 1'b0;
        hold <= 1'b0;
        repeat (300) @(posedge clk_i);
        ord_en <= 1'b0;
        trk_en <= 1'b0;
        while (n_orders != head_seq || mu_v || su_v) begin
            @(posedge clk_i);
        end
        repeat (5) @(posedge clk_i);
        $display("Finished after %0d cycles and %0d orders with %0d errors",
                 cycles, n_orders, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: coherence_ctrl.f
+incdir+verilog
verilog/coherence_ctrl_pkg.sv
verilog/line_tracker.sv
verilog/cd_order_queue.sv
verilog/cd_router.sv
verilog/coherence_ctrl.sv
test/tb_coherence_ctrl.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f coherence_ctrl.f \
    --top-module tb_coherence_ctrl -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "All tests passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
